// ==== vga_capture_testdata.txt ====
# L n p..: line of n pixel bytes in hex, hsync high | V f: vsync pulse, f expected pulses
# E e: enable level | R s n w..: read a bank of size s, check first n words (bytes in hex)
E 1
# capture and packing
L 5 a3 1c 42 ff 00
R 5 5 a3 1c 42 ff 00
# ping-pong order, then a third line while both banks are full
L 4 11 22 33 44
L 3 e0 1f 5a
L 2 99 66
R 4 4 11 22 33 44
R 3 3 e0 1f 5a
R 0 0
L 3 c3 3c 81
R 3 3 c3 3c 81
# full bank
L 16 5e 6f 70 81 92 a3 b4 c5 d6 e7 f8 09 1a 2b 3c 4d
R 16 16 5e 6f 70 81 92 a3 b4 c5 d6 e7 f8 09 1a 2b 3c 4d
# enable low, then frame end
E 0
L 3 77 88 99
V 0
R 0 0
E 1
V 1
# partial read frees the bank
L 4 de ad be ef
R 4 2 de ad
L 2 13 57
L 3 24 68 ac
R 2 2 13 57
R 3 3 24 68 ac

// ==== vlog.f ====
+incdir+.
vga_cap_pkg.sv
ppfifo_wr_if.sv
ppfifo.sv
vga_to_ppfifo.sv
vga_capture_top.sv
tb_clkgen.sv
tb_vga_capture.sv

// ==== Bender.yml ====
package:
  name: vga_capture

export_include_dirs:
  - .

sources:
  - vga_cap_pkg.sv
  - ppfifo_wr_if.sv
  - ppfifo.sv
  - vga_to_ppfifo.sv
  - vga_capture_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_vga_capture.sv

// ==== tb_vga_capture.sv ====
module tb_vga_capture;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINE_GAP    = 6;   // low hsync cycles between lines
  localparam int READY_WAIT  = 40;  // cycles allowed for a bank to be offered
  localparam int IDLE_CHECK  = 20;
  localparam int REC_CYCLES  = 60;
  localparam int BASE_CYCLES = 200;

  logic                    clk;
  logic                    rst;
  logic                    i_enable;
  logic                    i_vga_hsync;
  logic                    i_vga_vsync;
  logic [2:0]              i_vga_red;
  logic [2:0]              i_vga_green;
  logic [1:0]              i_vga_blue;
  logic                    o_frame_finished;
  logic                    o_rfifo_ready;
  vga_cap_pkg::fifo_word_t o_rfifo_data;
  vga_cap_pkg::fifo_size_t o_rfifo_size;
  logic                    i_rfifo_activate;
  logic                    i_rfifo_strobe;

  // parsed records
  logic [7:0] kind_q  [$];
  int         arg1_q  [$];
  int         arg2_q  [$];
  int         start_q [$];
  logic [7:0] byte_q  [$];

  int   err_cnt    = 0;
  int   chk_cnt    = 0;
  int   pulse_cnt  = 0;
  int   exp_pulses = 0;
  logic load_done  = 1'b0;

  tb_clkgen u_clkgen (
    .clk (clk)
  );

  vga_capture_top u_vga_capture_top (
    .clk              (clk),
    .rst              (rst),
    .i_enable         (i_enable),
    .i_vga_hsync      (i_vga_hsync),
    .i_vga_vsync      (i_vga_vsync),
    .i_vga_red        (i_vga_red),
    .i_vga_green      (i_vga_green),
    .i_vga_blue       (i_vga_blue),
    .o_frame_finished (o_frame_finished),
    .o_rfifo_ready    (o_rfifo_ready),
    .o_rfifo_data     (o_rfifo_data),
    .o_rfifo_size     (o_rfifo_size),
    .i_rfifo_activate (i_rfifo_activate),
    .i_rfifo_strobe   (i_rfifo_strobe)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  // inputs move 10 ns after the edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic load_records();
    int fd;
    int c;
    int n;
    int s;
    int v;
    int i;
    int code;
    logic [8*160-1:0] skip_line;
    fd = $fopen("vga_capture_testdata.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open vga_capture_testdata.txt, no stimulus was run");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          code = $fgets(skip_line, fd);  // rest of a comment line
        end else if (c == "L" || c == "R") begin
          code = $fscanf(fd, "%d", s);
          n = s;
          if (c == "R") code = $fscanf(fd, "%d", n);
          kind_q.push_back(c[7:0]);
          arg1_q.push_back(s);
          arg2_q.push_back(n);
          start_q.push_back(byte_q.size());
          for (i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", v);
            byte_q.push_back(v[7:0]);
          end
        end else if (c == "V" || c == "E") begin
          code = $fscanf(fd, "%d", v);
          kind_q.push_back(c[7:0]);
          arg1_q.push_back(v);
          arg2_q.push_back(0);
          start_q.push_back(byte_q.size());
        end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
          err_cnt++;
          $display("unknown record type '%c' in vga_capture_testdata.txt", c[7:0]);
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_line(input int first, input int n);
    int i;
    logic [7:0] p;
    for (i = 0; i < n; i++) begin
      p           = byte_q[first + i];
      i_vga_hsync = 1'b1;
      i_vga_red   = p[7:5];
      i_vga_green = p[4:2];
      i_vga_blue  = p[1:0];
      step();
    end
    i_vga_hsync = 1'b0;
    i_vga_red   = '0;
    i_vga_green = '0;
    i_vga_blue  = '0;
    repeat (LINE_GAP) step();
  endtask

  task automatic read_bank(input int exp_size, input int n_words, input int first);
    int i;
    int waited;
    if (exp_size == 0) begin
      // nothing may be offered
      for (i = 0; i < IDLE_CHECK; i++) begin
        check_value("o_rfifo_ready", o_rfifo_ready, 32'h0);
        step();
      end
    end else begin
      waited = 0;
      while (!o_rfifo_ready && waited < READY_WAIT) begin
        step();
        waited++;
      end
      if (!o_rfifo_ready) begin
        err_cnt++;
        $display("no filled bank was offered for a read of %0d words at %0t ns",
                 exp_size, $time);
      end else begin
        check_value("o_rfifo_size", o_rfifo_size, exp_size);
        i_rfifo_activate = 1'b1;
        step();
        check_value("o_rfifo_ready", o_rfifo_ready, 32'h0);
        step();  // word 0 valid now
        for (i = 0; i < n_words; i++) begin
          check_value("o_rfifo_data", o_rfifo_data, {24'h0, byte_q[first + i]});
          if (i < n_words - 1) begin
            i_rfifo_strobe = 1'b1;
            step();
            i_rfifo_strobe = 1'b0;
            step();
          end
        end
        i_rfifo_activate = 1'b0;  // drop activate to free the bank
        repeat (3) step();
      end
    end
  endtask

  task automatic pulse_vsync(input int exp_pulse);
    int i;
    i_vga_vsync = 1'b1;
    for (i = 0; i < 3; i++) begin
      step();
      check_value("o_frame_finished", o_frame_finished, 32'h0);
    end
    i_vga_vsync = 1'b0;
    step();  // edge that samples vsync low
    check_value("o_frame_finished", o_frame_finished, exp_pulse);
    step();
    check_value("o_frame_finished", o_frame_finished, 32'h0);
    repeat (2) step();
  endtask

  task automatic set_enable(input int level);
    i_enable = level[0];
    repeat (4) step();  // let the writer claim a bank
  endtask

  always @(posedge clk) begin
    if (!rst && o_frame_finished) pulse_cnt <= pulse_cnt + 1;
  end

  initial begin : watchdog
    int limit;
    wait (load_done);
    limit = kind_q.size() * REC_CYCLES + BASE_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, the test sequence did not complete", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    int r;
    rst              = 1'b1;
    i_enable         = 1'b0;
    i_vga_hsync      = 1'b0;
    i_vga_vsync      = 1'b0;
    i_vga_red        = '0;
    i_vga_green      = '0;
    i_vga_blue       = '0;
    i_rfifo_activate = 1'b0;
    i_rfifo_strobe   = 1'b0;

    load_records();
    load_done = 1'b1;

    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;
    repeat (2) step();

    for (r = 0; r < kind_q.size(); r++) begin
      case (kind_q[r])
        "L": drive_line(start_q[r], arg1_q[r]);
        "R": read_bank(arg1_q[r], arg2_q[r], start_q[r]);
        "V": begin
          pulse_vsync(arg1_q[r]);
          exp_pulses += arg1_q[r];
        end
        "E": set_enable(arg1_q[r]);
        default: begin
          err_cnt++;
          $display("record %0d has no handler", r);
        end
      endcase
    end

    repeat (4) step();
    check_value("o_frame_finished pulses", pulse_cnt, exp_pulses);

    $display("%0d records, %0d checks, %0d errors", kind_q.size(), chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam real HALF_PERIOD = 50.0;  // 100 ns clock

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== vga_capture_top.sv ====
module vga_capture_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_enable,
  input  logic                    i_vga_hsync,
  input  logic                    i_vga_vsync,
  input  logic [2:0]              i_vga_red,
  input  logic [2:0]              i_vga_green,
  input  logic [1:0]              i_vga_blue,
  output logic                    o_frame_finished,
  output logic                    o_rfifo_ready,
  output vga_cap_pkg::fifo_word_t o_rfifo_data,
  output vga_cap_pkg::fifo_size_t o_rfifo_size,
  input  logic                    i_rfifo_activate,
  input  logic                    i_rfifo_strobe
);

  ppfifo_wr_if wr_if ();

  vga_to_ppfifo u_vga_to_ppfifo (
    .clk              (clk),
    .rst              (rst),
    .i_enable         (i_enable),
    .i_vga_hsync      (i_vga_hsync),
    .i_vga_vsync      (i_vga_vsync),
    .i_vga_red        (i_vga_red),
    .i_vga_green      (i_vga_green),
    .i_vga_blue       (i_vga_blue),
    .o_frame_finished (o_frame_finished),
    .wr               (wr_if.writer)
  );

  // read side goes straight out
  ppfifo u_ppfifo (
    .clk              (clk),
    .rst              (rst),
    .wr               (wr_if.fifo),
    .o_rfifo_ready    (o_rfifo_ready),
    .i_rfifo_activate (i_rfifo_activate),
    .i_rfifo_strobe   (i_rfifo_strobe),
    .o_rfifo_data     (o_rfifo_data),
    .o_rfifo_size     (o_rfifo_size)
  );

endmodule

// ==== vga_to_ppfifo.sv ====
module vga_to_ppfifo (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_enable,
  input  logic        i_vga_hsync,  // active video qualifier
  input  logic        i_vga_vsync,
  input  logic [2:0]  i_vga_red,
  input  logic [2:0]  i_vga_green,
  input  logic [1:0]  i_vga_blue,
  output logic        o_frame_finished,
  ppfifo_wr_if.writer wr
);

  localparam int PAD_W = $bits(vga_cap_pkg::fifo_word_t) - $bits(vga_cap_pkg::rgb332_t);

  vga_cap_pkg::rgb332_t    pixel;
  vga_cap_pkg::bank_sel_t  r_activate;
  vga_cap_pkg::fifo_size_t r_count;
  vga_cap_pkg::fifo_word_t r_data;
  logic                    r_strobe;
  logic                    r_prev_vsync;

  logic owned;
  logic line_full;
  logic accept;
  logic vsync_fall;

  assign pixel      = '{red: i_vga_red, green: i_vga_green, blue: i_vga_blue};
  assign owned      = (r_activate != '0);
  assign line_full  = (r_count == wr.size);
  assign accept     = i_enable && i_vga_hsync && owned && !line_full;
  assign vsync_fall = r_prev_vsync && !i_vga_vsync;

  assign wr.activate = r_activate;
  assign wr.strobe   = r_strobe;
  assign wr.data     = r_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_activate       <= '0;
      r_count          <= '0;
      r_strobe         <= 1'b0;
      r_prev_vsync     <= 1'b0;
      o_frame_finished <= 1'b0;
    end else begin
      r_strobe         <= accept;
      r_prev_vsync     <= i_vga_vsync;
      o_frame_finished <= i_enable && vsync_fall;

      if (!owned) begin
        // grab the lower free bank
        if (i_enable && (wr.ready != '0)) begin
          r_activate <= wr.ready[0] ? 2'b01 : 2'b10;
          r_count    <= '0;
        end
      end else if (line_full || (!i_vga_hsync && (r_count != '0))) begin
        r_activate <= '0;  // last strobe lands on this edge
      end else if (accept) begin
        r_count <= r_count + 1'b1;
      end
    end
  end

  // pixel sits in the low byte
  always_ff @(posedge clk) begin
    if (accept) r_data <= {{PAD_W{1'b0}}, pixel};
  end

  a_one_bank : assert property (
    @(posedge clk) disable iff (rst)
    wr.activate != 2'b11
  );

  a_strobe_owned : assert property (
    @(posedge clk) disable iff (rst)
    wr.strobe |-> (wr.activate != '0)
  );

  a_frame_pulse : assert property (
    @(posedge clk) disable iff (rst)
    o_frame_finished |=> !o_frame_finished
  );

endmodule

// ==== ppfifo.sv ====
`include "vga_cap_cfg.svh"

module ppfifo (
  input  logic                    clk,
  input  logic                    rst,
  ppfifo_wr_if.fifo               wr,
  output logic                    o_rfifo_ready,
  input  logic                    i_rfifo_activate,
  input  logic                    i_rfifo_strobe,
  output vga_cap_pkg::fifo_word_t o_rfifo_data,
  output vga_cap_pkg::fifo_size_t o_rfifo_size
);

  localparam int unsigned DEPTH = 1 << `VGA_CAP_ADDR_W;

  typedef enum logic [1:0] {
    BANK_EMPTY,
    BANK_WRITING,
    BANK_FILLED
  } bank_state_t;

  vga_cap_pkg::fifo_word_t mem [2][DEPTH];

  bank_state_t             state [2];
  vga_cap_pkg::fifo_size_t count [2];
  logic [1:0]              fill_evt;
  logic [1:0]              wr_evt;

  logic                        rd_bank;  // oldest filled bank
  logic                        rd_active;
  logic [`VGA_CAP_ADDR_W-1:0]  rd_ptr;
  logic                        rd_release;

  assign wr.size  = vga_cap_pkg::fifo_size_t'(DEPTH);
  assign wr.ready = {state[1] == BANK_EMPTY, state[0] == BANK_EMPTY};

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      // writer let go of the bank this cycle
      fill_evt[b] = (state[b] == BANK_WRITING) && !wr.activate[b];
      wr_evt[b]   = (state[b] == BANK_WRITING) && wr.activate[b] && wr.strobe;
    end
  end

  assign rd_release    = rd_active && !i_rfifo_activate;
  assign o_rfifo_ready = (state[rd_bank] == BANK_FILLED) && !rd_active;
  assign o_rfifo_size  = count[rd_bank];

  // bank state and word counts
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        state[b] <= BANK_EMPTY;
        count[b] <= '0;
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (state[b])
          BANK_EMPTY: begin
            if (wr.activate[b]) begin
              state[b] <= BANK_WRITING;
              count[b] <= '0;
            end
          end
          BANK_WRITING: begin
            if (fill_evt[b]) begin
              state[b] <= BANK_FILLED;
            end else if (wr_evt[b]) begin
              count[b] <= count[b] + 1'b1;
            end
          end
          BANK_FILLED: begin
            if (rd_release && (rd_bank == b[0])) state[b] <= BANK_EMPTY;
          end
          default: state[b] <= BANK_EMPTY;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (wr_evt[b]) mem[b][count[b][`VGA_CAP_ADDR_W-1:0]] <= wr.data;
    end
  end

  // read ownership and fill order
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_bank   <= 1'b0;
      rd_active <= 1'b0;
      rd_ptr    <= '0;
    end else begin
      if (!rd_active) begin
        if (i_rfifo_activate && o_rfifo_ready) begin
          rd_active <= 1'b1;
          rd_ptr    <= '0;
        end
      end else if (rd_release) begin
        rd_active <= 1'b0;
      end else if (i_rfifo_strobe) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      if (rd_release) begin
        rd_bank <= !rd_bank;  // other bank is next oldest
      end else if (fill_evt[!rd_bank] && (state[rd_bank] != BANK_FILLED)) begin
        rd_bank <= !rd_bank;  // head not filled yet so the new fill leads
      end
    end
  end

  always_ff @(posedge clk) begin
    o_rfifo_data <= mem[rd_bank][rd_ptr];
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank_chk
    // writer may only claim a bank that was offered
    a_activate_ready : assert property (
      @(posedge clk) disable iff (rst)
      $rose(wr.activate[b]) |-> $past(wr.ready[b])
    );

    a_wr_depth : assert property (
      @(posedge clk) disable iff (rst)
      wr_evt[b] |-> (count[b] < vga_cap_pkg::fifo_size_t'(DEPTH))
    );
  end

  a_rd_strobe_active : assert property (
    @(posedge clk) disable iff (rst)
    i_rfifo_strobe |-> rd_active
  );

endmodule

// ==== ppfifo_wr_if.sv ====
interface ppfifo_wr_if;

  vga_cap_pkg::bank_sel_t  ready;     // bank empty and free
  vga_cap_pkg::bank_sel_t  activate;  // bank owned by writer
  vga_cap_pkg::fifo_size_t size;      // bank depth
  logic                    strobe;
  vga_cap_pkg::fifo_word_t data;

  modport writer (
    input  ready,
    input  size,
    output activate,
    output strobe,
    output data
  );

  modport fifo (
    output ready,
    output size,
    input  activate,
    input  strobe,
    input  data
  );

endinterface

// ==== vga_cap_pkg.sv ====
`include "vga_cap_cfg.svh"

package vga_cap_pkg;

  // rgb332 pixel as it arrives from the vga pins
  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } rgb332_t;

  typedef logic [`VGA_CAP_DATA_W-1:0] fifo_word_t;

  typedef logic [23:0] fifo_size_t;  // words held in a bank

  typedef logic [1:0] bank_sel_t;  // one bit per bank

endpackage

// ==== vga_cap_cfg.svh ====
`ifndef VGA_CAP_CFG_SVH
`define VGA_CAP_CFG_SVH

// log2 of words per bank
`define VGA_CAP_ADDR_W 4

// width of one fifo word
`define VGA_CAP_DATA_W 32

`endif
